/* hdl/axis_merge_top.sv */
// Two-input packet merge: lossless input A, tail-dropping input B
// Each input is buffered in its own FIFO ahead of the packet arbiter

`timescale 1ns/10ps

module axis_merge_top
    import axis_pkg::*;
#(
    parameter int depth = 64
) (
    input  logic              axis_out,
    input  logic              rst_n,

    input  axis_beat_t        in_a_beat,
    input  logic              in_a_valid,
    output logic              in_a_ready,

    input  axis_beat_t        in_b_beat,
    input  logic              in_b_valid,
    output logic              in_b_ready,

    output axis_tagged_beat_t out_beat,
    output logic              out_valid,
    input  logic              out_ready,

    output logic              in_a_overflow,
    output logic              in_b_overflow
);

    axis_beat_t fifo_a_beat;
    logic       fifo_a_valid;
    logic       fifo_a_ready;
    axis_beat_t fifo_b_beat;
    logic       fifo_b_valid;
    logic       fifo_b_ready;

    ////////////////////
    // Input buffers

    // Input A stalls its source when full
    axis_word_fifo #(
        .depth              (depth),
        .allow_backpressure (1'b1)
    ) fifo_a (
        .axis_out  (axis_out),
        .rst_n     (rst_n),
        .in_beat   (in_a_beat),
        .in_valid  (in_a_valid),
        .in_ready  (in_a_ready),
        .out_beat  (fifo_a_beat),
        .out_valid (fifo_a_valid),
        .out_ready (fifo_a_ready),
        .overflow  (in_a_overflow)
    );

    // Input B is never stalled and loses packet tails instead
    axis_word_fifo #(
        .depth              (depth),
        .allow_backpressure (1'b0)
    ) fifo_b (
        .axis_out  (axis_out),
        .rst_n     (rst_n),
        .in_beat   (in_b_beat),
        .in_valid  (in_b_valid),
        .in_ready  (in_b_ready),
        .out_beat  (fifo_b_beat),
        .out_valid (fifo_b_valid),
        .out_ready (fifo_b_ready),
        .overflow  (in_b_overflow)
    );

    ////////////////////
    // Merge

    packet_arbiter arb (
        .axis_out  (axis_out),
        .rst_n     (rst_n),
        .a_beat    (fifo_a_beat),
        .a_valid   (fifo_a_valid),
        .a_ready   (fifo_a_ready),
        .b_beat    (fifo_b_beat),
        .b_valid   (fifo_b_valid),
        .b_ready   (fifo_b_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* hdl/axis_pkg.sv */
// Shared stream types for the two-input packet merge
// Import into any module that carries beats or needs the arbiter state

package axis_pkg;

    ////////////////////
    // Word geometry

    // Bytes per data word, tkeep has one bit per byte
    localparam int data_bytes = 4;

    ////////////////////
    // Beat types

    // One stream beat as it sits in a FIFO entry
    typedef struct packed {
        logic [data_bytes*8-1:0] tdata;
        logic [data_bytes-1:0]   tkeep;
        logic                    tlast;
    } axis_beat_t;

    // Merged output beat, src is 0 for input A and 1 for input B
    typedef struct packed {
        logic       src;
        axis_beat_t beat;
    } axis_tagged_beat_t;

    ////////////////////
    // Arbiter FSM

    // Grant state, held from first beat to tlast
    typedef enum logic [1:0] {
        arb_idle,
        arb_src_a,
        arb_src_b
    } arb_state_t;

endpackage

/* hdl/axis_word_fifo.sv */
// Word FIFO for one stream input, with a primed output register
// Either back-pressures when full or drops the rest of the packet and flags overflow

`timescale 1ns/10ps

module axis_word_fifo
    import axis_pkg::*;
#(
    parameter int depth              = 64,
    parameter bit allow_backpressure = 1'b1
) (
    input  logic       axis_out,
    input  logic       rst_n,

    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,

    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready,

    output logic       overflow
);

    ////////////////////
    // Constants

    localparam int aw     = $clog2(depth);
    localparam int fill_w = aw + 1;

    // One entry of guard band below the array size
    localparam logic [fill_w-1:0] full_level = fill_w'(depth - 1);

    if ((1 << aw) != depth || depth < 4) begin : g_depth_check
        $error("axis_word_fifo: depth must be a power of two, at least 4");
    end

    ////////////////////
    // Signals

    axis_beat_t        mem [depth];
    axis_beat_t        rd_beat;
    logic [aw-1:0]     wr_ptr;
    logic [aw-1:0]     rd_ptr;
    logic [fill_w-1:0] fill;
    logic [fill_w-1:0] fill_next;
    logic              full;
    logic              drop;
    logic              wr_en;
    logic              rd_en;
    logic              mem_empty;
    logic              load;

    ////////////////////
    // Write side

    // Without back-pressure the input is always ready and excess words are lost
    assign in_ready = !full || !allow_backpressure;

    // Nothing of a packet is stored once it has lost a word
    assign wr_en = in_valid && in_ready && !full && !drop;

    always_ff @(posedge axis_out) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            drop     <= 1'b0;
            overflow <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (wr_en) begin
                wr_ptr <= wr_ptr + aw'(1);
            end
            if (in_valid && in_ready) begin
                if (in_beat.tlast) begin
                    // Report at the end of any packet that lost a word
                    overflow <= drop || full;
                    drop     <= 1'b0;
                end else if (full) begin
                    drop <= 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Occupancy

    // Counts words in the array plus the one in the output register
    assign fill_next = fill + fill_w'(wr_en) - fill_w'(rd_en);

    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            fill <= '0;
            full <= 1'b0;
        end else begin
            fill <= fill_next;
            full <= (fill_next >= full_level);
        end
    end

    ////////////////////
    // Read side

    assign rd_beat   = mem[rd_ptr];
    assign mem_empty = (rd_ptr == wr_ptr);
    assign rd_en     = out_valid && out_ready;

    // Refill the output register when it empties or is being consumed
    assign load = !mem_empty && (rd_en || !out_valid);

    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (load) begin
                rd_ptr    <= rd_ptr + aw'(1);
                out_valid <= 1'b1;
            end else if (rd_en) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_out) begin
        if (load) begin
            out_beat <= rd_beat;
        end
    end

    ////////////////////
    // Checks

    // Lossless mode never fills past the guard band
    a_lossless: assert property (
        @(posedge axis_out) disable iff (!rst_n)
        allow_backpressure |-> (fill <= full_level)
    );

    a_out_hold: assert property (
        @(posedge axis_out) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat)
    );

endmodule

/* hdl/packet_arbiter.sv */
// Round-robin merge of two beat streams at packet granularity
// Output is registered and each beat carries the tag of its source

`timescale 1ns/10ps

module packet_arbiter
    import axis_pkg::*;
(
    input  logic              axis_out,
    input  logic              rst_n,

    input  axis_beat_t        a_beat,
    input  logic              a_valid,
    output logic              a_ready,

    input  axis_beat_t        b_beat,
    input  logic              b_valid,
    output logic              b_ready,

    output axis_tagged_beat_t out_beat,
    output logic              out_valid,
    input  logic              out_ready
);

    ////////////////////
    // Signals

    arb_state_t state;
    logic       prio_b;
    logic       pick_a;
    logic       pick_b;
    logic       grant_a;
    logic       grant_b;
    logic       take_a;
    logic       take_b;
    logic       done_a;
    logic       done_b;

    ////////////////////
    // Grant

    // Preferred source wins in idle, the other one only if the preferred is absent
    assign pick_a = a_valid && (!prio_b || !b_valid);
    assign pick_b = b_valid && (prio_b || !a_valid);

    // Grant takes effect in the idle cycle so the first beat is not delayed
    assign grant_a = (state == arb_src_a) || ((state == arb_idle) && pick_a);
    assign grant_b = (state == arb_src_b) || ((state == arb_idle) && pick_b);

    // Stage loads only while the sink is ready, so a stall leaves all buffering in the FIFOs
    assign a_ready = grant_a && out_ready;
    assign b_ready = grant_b && out_ready;

    assign take_a = a_valid && a_ready;
    assign take_b = b_valid && b_ready;
    assign done_a = take_a && a_beat.tlast;
    assign done_b = take_b && b_beat.tlast;

    ////////////////////
    // FSM

    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            state  <= arb_idle;
            prio_b <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    // Single-beat packets finish in the cycle they are granted
                    if (pick_a && !done_a) begin
                        state <= arb_src_a;
                    end else if (pick_b && !done_b) begin
                        state <= arb_src_b;
                    end
                end
                arb_src_a: begin
                    if (done_a) begin
                        state <= arb_idle;
                    end
                end
                arb_src_b: begin
                    if (done_b) begin
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase

            // Hand preference to the other source after every packet
            if (done_a) begin
                prio_b <= 1'b1;
            end else if (done_b) begin
                prio_b <= 1'b0;
            end
        end
    end

    ////////////////////
    // Output stage

    always_ff @(posedge axis_out or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= take_a || take_b;
        end
    end

    always_ff @(posedge axis_out) begin
        if (take_a) begin
            out_beat <= '{src: 1'b0, beat: a_beat};
        end else if (take_b) begin
            out_beat <= '{src: 1'b1, beat: b_beat};
        end
    end

    ////////////////////
    // Checks

    a_one_grant: assert property (
        @(posedge axis_out) disable iff (!rst_n)
        !(a_ready && b_ready)
    );

    a_out_hold: assert property (
        @(posedge axis_out) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat)
    );

endmodule

/* src.f */
+incdir+verification
hdl/axis_pkg.sv
hdl/axis_word_fifo.sv
hdl/packet_arbiter.sv
hdl/axis_merge_top.sv
verification/tb_axis_merge.sv

/* verification/tb_ref_model.svh */
// Reference model for the merge testbench, included inside its top module
// Expected beats per source, FIFO fill and tail-drop model, round-robin prediction
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

    ////////////////////
    // Model state

    axis_beat_t exp_a[$];
    axis_beat_t exp_b[$];

    // Words written into each FIFO and beats seen leaving the output
    int a_written = 0;
    int a_out     = 0;
    int b_written = 0;
    int b_out     = 0;

    // Tail-drop state of input B
    logic b_drop        = 1'b0;
    logic b_ovf_exp     = 1'b0;
    logic b_tail_closed = 1'b1;

    // Round-robin preference, source A after reset
    logic model_prio_b = 1'b0;

    ////////////////////
    // Rules

    // Words still inside a FIFO, one may sit in the arbiter output stage
    function automatic int fifo_occupancy(input int written, input int sent, input logic held);
        return written - sent - int'(held);
    endfunction

    // Guard band of one entry below the FIFO size
    function automatic logic fifo_is_full(input int occupancy);
        return occupancy >= fifo_depth - 1;
    endfunction

    // Applies the tail-drop rule to one beat accepted on input B, returns 1 if it is stored
    function automatic logic tail_drop_store(input axis_beat_t beat, input logic full);
        logic store;
        store = !full && !b_drop;
        if (beat.tlast) begin
            b_ovf_exp = b_drop || full;
            b_drop    = 1'b0;
        end else if (full) begin
            b_drop = 1'b1;
        end
        return store;
    endfunction

    // Source of the next packet, the preferred one wins when both wait
    function automatic logic predict_src(input logic prio_b, input bit a_avail, input bit b_avail);
        if (a_avail && b_avail) begin
            return prio_b;
        end
        return b_avail;
    endfunction

`endif

/* verification/tb_axis_merge.sv */
// Testbench for the two-input packet merge
// Drives both inputs and the output ready, checks every output beat against the reference model

`timescale 1ns/10ps

module tb_axis_merge
    import axis_pkg::*;
();

    localparam int fifo_depth   = 16;
    localparam int wait_limit   = 4000;
    localparam int ready_low    = 0;
    localparam int ready_high   = 1;
    localparam int ready_random = 2;

    logic              axis_out;
    logic              rst_n;
    axis_beat_t        in_a_beat;
    logic              in_a_valid;
    logic              in_a_ready;
    axis_beat_t        in_b_beat;
    logic              in_b_valid;
    logic              in_b_ready;
    axis_tagged_beat_t out_beat;
    logic              out_valid;
    logic              out_ready;
    logic              in_a_overflow;
    logic              in_b_overflow;

    int   ready_mode = ready_low;
    logic rr_check   = 1'b0;
    logic in_pkt     = 1'b0;
    logic cur_src    = 1'b0;
    int   a_start;

    `include "tb_ref_model.svh"

    axis_merge_top #(.depth(fifo_depth)) DUT (.*);

    initial begin
        axis_out = 1'b0;
        forever #10 axis_out = ~axis_out;
    end

    ////////////////////
    // Checks

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_beat(input string name, input axis_tagged_beat_t got,
                              input axis_tagged_beat_t exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s expected 0x%h got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("error %s expected 0x%h got 0x%h", name, exp, got));
        end
    endtask

    // Pops the queue of the beat's source and checks packet boundaries
    task automatic check_output(input axis_tagged_beat_t got);
        axis_tagged_beat_t exp;
        if (got.src ? exp_b.size() == 0 : exp_a.size() == 0) begin
            report_failure("output beat arrived with no expected beat for its source");
        end
        if (in_pkt && got.src != cur_src) begin
            report_failure("packets from the two sources were interleaved");
        end
        if (!in_pkt && rr_check) begin
            check_flag("out_beat.src", got.src,
                       predict_src(model_prio_b, exp_a.size() != 0, exp_b.size() != 0));
        end
        exp.src = got.src;
        if (got.src) begin
            exp.beat = exp_b.pop_front();
            b_out++;
        end else begin
            exp.beat = exp_a.pop_front();
            a_out++;
        end
        check_beat("out_beat", got, exp);
        cur_src = got.src;
        in_pkt  = !got.beat.tlast;
        if (got.beat.tlast) begin
            model_prio_b = !got.src;
        end
    endtask

    // Values read here are the ones the DUT sees at this edge
    always @(posedge axis_out) begin : monitor
        int occ_a;
        int occ_b;
        if (rst_n) begin
            occ_a = fifo_occupancy(a_written, a_out, out_valid && !out_beat.src);
            occ_b = fifo_occupancy(b_written, b_out, out_valid && out_beat.src);
            check_flag("in_a_ready", in_a_ready, !fifo_is_full(occ_a));
            check_flag("in_b_ready", in_b_ready, 1'b1);
            check_flag("in_a_overflow", in_a_overflow, 1'b0);
            check_flag("in_b_overflow", in_b_overflow, b_ovf_exp);
            b_ovf_exp = 1'b0;
            if (in_a_valid && in_a_ready) begin
                exp_a.push_back(in_a_beat);
                a_written++;
            end
            if (in_b_valid && in_b_ready) begin
                if (tail_drop_store(in_b_beat, fifo_is_full(occ_b))) begin
                    exp_b.push_back(in_b_beat);
                    b_written++;
                    b_tail_closed = in_b_beat.tlast;
                end
            end
            if (out_valid && out_ready) begin
                check_output(out_beat);
            end
        end
    end

    ////////////////////
    // Stimulus

    function automatic axis_beat_t make_beat(input int idx, input int len);
        axis_beat_t beat;
        beat.tdata = $urandom;
        beat.tlast = (idx == len - 1);
        beat.tkeep = '1;
        if (beat.tlast) begin
            beat.tkeep = $urandom;
            if (beat.tkeep == '0) begin
                beat.tkeep = '1;
            end
        end
        return beat;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge axis_out);
    endtask

    task automatic send_packet_a(input int len);
        int waited;
        for (int i = 0; i < len; i++) begin
            @(negedge axis_out);
            in_a_beat  = make_beat(i, len);
            in_a_valid = 1'b1;
            waited     = 0;
            do begin
                @(posedge axis_out);
                waited++;
                if (waited > wait_limit) begin
                    report_failure("timed out waiting for in_a_ready");
                end
            end while (!in_a_ready);
        end
        @(negedge axis_out);
        in_a_valid = 1'b0;
    endtask

    task automatic send_packet_b(input int len);
        int waited;
        for (int i = 0; i < len; i++) begin
            @(negedge axis_out);
            in_b_beat  = make_beat(i, len);
            in_b_valid = 1'b1;
            waited     = 0;
            do begin
                @(posedge axis_out);
                waited++;
                if (waited > wait_limit) begin
                    report_failure("timed out waiting for in_b_ready");
                end
            end while (!in_b_ready);
        end
        @(negedge axis_out);
        in_b_valid = 1'b0;
    endtask

    task automatic random_traffic(input bit use_b, input int packets);
        int tries;
        for (int p = 0; p < packets; p++) begin
            if (use_b) begin
                send_packet_b(1 + $urandom % 6);
            end else begin
                send_packet_a(1 + $urandom % 6);
            end
            idle_cycles($urandom % 8);
        end
        // A truncated B packet holds the arbiter on B until a stored tlast closes it
        tries = 0;
        while (use_b && !b_tail_closed) begin
            tries++;
            if (tries > 20) begin
                report_failure("input B packet tail could not be closed");
            end
            send_packet_b(1);
        end
    endtask

    task automatic drive_out_ready();
        forever begin
            @(negedge axis_out);
            if (ready_mode == ready_random) begin
                out_ready = ($urandom % 4) != 0;
            end else begin
                out_ready = (ready_mode == ready_high);
            end
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_a.size() != 0 || exp_b.size() != 0 || out_valid) begin
            @(negedge axis_out);
            waited++;
            if (waited > wait_limit) begin
                report_failure("output did not drain all expected beats");
            end
        end
    endtask

    task automatic wait_a_written(input int level);
        int waited;
        waited = 0;
        while (a_written < level) begin
            @(negedge axis_out);
            waited++;
            if (waited > wait_limit) begin
                report_failure("input A stopped accepting beats too early");
            end
        end
    endtask

    task automatic wait_b_below(input int level);
        int waited;
        waited = 0;
        while (exp_b.size() >= level) begin
            @(negedge axis_out);
            waited++;
            if (waited > wait_limit) begin
                report_failure("FIFO B did not drain after release");
            end
        end
    endtask

    ////////////////////
    // Test sequence

    initial begin
        void'($urandom(43));
        rst_n      = 1'b0;
        in_a_beat  = '0;
        in_a_valid = 1'b0;
        in_b_beat  = '0;
        in_b_valid = 1'b0;
        out_ready  = 1'b0;
        fork
            drive_out_ready();
        join_none
        repeat (10) @(posedge axis_out);
        @(negedge axis_out);
        rst_n = 1'b1;
        @(negedge axis_out);

        // Idle outputs after reset
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_a_overflow", in_a_overflow, 1'b0);
        check_flag("in_b_overflow", in_b_overflow, 1'b0);
        check_flag("in_a_ready", in_a_ready, 1'b1);
        check_flag("in_b_ready", in_b_ready, 1'b1);

        // One packet per input, A wins and preference returns to A
        ready_mode = ready_high;
        fork
            send_packet_a(4);
            send_packet_b(3);
        join
        wait_drained();

        // Round robin over preloaded FIFOs
        ready_mode = ready_low;
        idle_cycles(2);
        fork
            repeat (3) send_packet_a(1 + $urandom % 4);
            repeat (3) send_packet_b(1 + $urandom % 4);
        join
        idle_cycles(4);
        rr_check   = 1'b1;
        ready_mode = ready_high;
        wait_drained();
        rr_check = 1'b0;

        // Concurrent random packets with a random sink
        ready_mode = ready_random;
        fork
            random_traffic(1'b0, 40);
            random_traffic(1'b1, 40);
        join
        wait_drained();

        // Overflow on B, back-pressure on A
        ready_mode = ready_low;
        idle_cycles(2);
        send_packet_b(20);
        a_start = a_written;
        fork
            send_packet_a(20);
            begin
                wait_a_written(a_start + fifo_depth - 1);
                check_flag("in_a_ready", in_a_ready, 1'b0);
                idle_cycles(5);
                ready_mode = ready_high;
                wait_b_below(8);
                send_packet_b(5);
            end
        join
        wait_drained();

        if (exp_a.size() != 0 || exp_b.size() != 0) begin
            report_failure("expected beats were never seen at the output");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule
